// File: design/core_pkg.sv
package core_pkg;

    // widths with a meaning
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // instruction bus request
    // addr is held until addr_ok
    typedef struct packed {
        logic  valid;
        word_t addr;
    } ibus_req_t;

    // instruction bus response
    // data is only meaningful with data_ok
    typedef struct packed {
        logic   addr_ok;
        logic   data_ok;
        dword_t data;
    } ibus_resp_t;

    // redirect strobe from a later stage
    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    // one decode slot
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t raw_instr;
        logic  pc_except;
    } fetch_slot_t;

    // fetch sequencing states
    typedef enum logic [1:0] {
        F_REQ,
        F_DATA,
        F_HOLD,
        F_EXC
    } fetch_state_t;

    // a PC at the odd word only steps to the next doubleword
    function automatic word_t pc_step(input word_t pc);
        word_t nxt;
        if (pc[2]) begin
            nxt = pc + 32'd4;
        end else begin
            nxt = pc + 32'd8;
        end
        return nxt;
    endfunction

endpackage

// File: design/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       dec_stall,
    input  logic       held,
    input  logic       pc_except,
    input  ibus_resp_t iresp,
    input  redirect_t  branch_redir,
    input  redirect_t  exc_redir,
    output logic       req_valid,
    output logic       pc_advance,
    output logic       capture,
    output logic       out_flush
);

    fetch_state_t state;
    fetch_state_t state_nxt;
    logic         discard;
    logic         redir_any;
    logic         accept;
    logic         blocked;

    assign redir_any = branch_redir.valid | exc_redir.valid;

    // the packet register cannot take new data this cycle
    assign blocked = held & dec_stall;

    // no request in reset, for a misaligned PC, or while the PC is being redirected
    assign req_valid = ~reset & (state == F_REQ) & ~pc_except & ~redir_any;
    assign accept    = req_valid & iresp.addr_ok;

    assign out_flush = redir_any;

    always_comb begin
        state_nxt  = state;
        capture    = 1'b0;
        pc_advance = 1'b0;
        case (state)
            F_REQ: begin
                if (redir_any) begin
                    state_nxt = F_REQ;
                end else if (pc_except) begin
                    // emit the exception packet once there is room for it
                    if (!blocked) begin
                        capture   = 1'b1;
                        state_nxt = F_EXC;
                    end
                end else if (accept) begin
                    state_nxt = F_DATA;
                end
            end
            F_DATA: begin
                if (iresp.data_ok) begin
                    if (discard || redir_any) begin
                        // stale doubleword is dropped and the new PC refetched
                        state_nxt = F_REQ;
                    end else if (blocked) begin
                        capture   = 1'b1;
                        state_nxt = F_HOLD;
                    end else begin
                        capture    = 1'b1;
                        pc_advance = 1'b1;
                        state_nxt  = F_REQ;
                    end
                end
            end
            F_HOLD: begin
                if (redir_any) begin
                    state_nxt = F_REQ;
                end else if (!dec_stall) begin
                    // saved doubleword moves into the packet
                    capture    = 1'b1;
                    pc_advance = 1'b1;
                    state_nxt  = F_REQ;
                end
            end
            F_EXC: begin
                if (redir_any) begin
                    state_nxt = F_REQ;
                end
            end
            default: begin
                state_nxt = F_REQ;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= F_REQ;
        end else begin
            state <= state_nxt;
        end
    end

    // a redirect while data is outstanding makes that data_ok stale
    always_ff @(posedge clk) begin
        if (reset) begin
            discard <= 1'b0;
        end else if (state == F_DATA) begin
            if (iresp.data_ok) begin
                discard <= 1'b0;
            end else if (redir_any) begin
                discard <= 1'b1;
            end
        end
    end

endmodule

// File: design/pc_gen.sv
`timescale 1ns/1ps

module pc_gen import core_pkg::*; #(
    parameter word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      pc_advance,
    input  redirect_t branch_redir,
    input  redirect_t exc_redir,
    output word_t     pc,
    output logic      pc_except
);

    word_t     pc_q;
    word_t     pc_nxt;
    redirect_t redir_sel;

    // exception redirect wins over a branch
    always_comb begin
        if (exc_redir.valid) begin
            redir_sel = exc_redir;
        end else begin
            redir_sel = branch_redir;
        end
    end

    // a redirect loads the PC directly and the next advance steps from the target
    always_comb begin
        pc_nxt = pc_q;
        if (redir_sel.valid) begin
            pc_nxt = redir_sel.target;
        end else if (pc_advance) begin
            pc_nxt = pc_step(pc_q);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_nxt;
        end
    end

    assign pc        = pc_q;
    assign pc_except = pc_q[1:0] != 2'b00;

endmodule

// File: design/fetch_align.sv
`timescale 1ns/1ps

module fetch_align import core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        capture,
    input  logic        out_flush,
    input  logic        dec_stall,
    input  word_t       fetch_pc,
    input  logic        pc_except,
    input  ibus_resp_t  iresp,
    output fetch_slot_t [1:0] slots,
    output logic        slots_valid,
    output logic        held
);

    fetch_slot_t [1:0] pkt;
    fetch_slot_t [1:0] pkt_nxt;
    logic              pkt_valid;

    // doubleword that arrived while decode was stalled
    // the PC stays frozen until it moves into the packet
    logic              sv_valid;
    dword_t            sv_data;

    dword_t            src_data;
    logic              src_except;

    assign src_data   = sv_valid ? sv_data : iresp.data;
    assign src_except = ~sv_valid & pc_except;

    // split the doubleword into two slots
    always_comb begin
        pkt_nxt[0].valid     = 1'b1;
        pkt_nxt[0].pc        = fetch_pc;
        pkt_nxt[0].pc_except = src_except;
        if (src_except) begin
            pkt_nxt[0].raw_instr = '0;
        end else if (fetch_pc[2]) begin
            pkt_nxt[0].raw_instr = src_data[63:32];
        end else begin
            pkt_nxt[0].raw_instr = src_data[31:0];
        end

        // second slot only when the PC starts the doubleword
        pkt_nxt[1].valid     = ~fetch_pc[2] & ~src_except;
        pkt_nxt[1].pc        = fetch_pc + 32'd4;
        pkt_nxt[1].raw_instr = src_data[63:32];
        pkt_nxt[1].pc_except = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_valid <= 1'b0;
            sv_valid  <= 1'b0;
        end else if (out_flush) begin
            pkt_valid <= 1'b0;
            sv_valid  <= 1'b0;
        end else if (capture) begin
            if (pkt_valid && dec_stall) begin
                sv_valid <= 1'b1;
            end else begin
                pkt_valid <= 1'b1;
                sv_valid  <= 1'b0;
            end
        end else if (!dec_stall) begin
            // decode took the packet
            pkt_valid <= 1'b0;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (capture && !out_flush) begin
            if (pkt_valid && dec_stall) begin
                sv_data <= iresp.data;
            end else begin
                pkt <= pkt_nxt;
            end
        end
    end

    // stale slot contents never reach decode without slots_valid
    always_comb begin
        slots = pkt;
        if (!pkt_valid) begin
            slots[0].valid = 1'b0;
            slots[1].valid = 1'b0;
        end
    end

    assign slots_valid = pkt_valid;
    assign held        = pkt_valid;

endmodule

// File: design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import core_pkg::*; #(
    parameter word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic        clk,
    input  logic        reset,
    output ibus_req_t   ireq,
    input  ibus_resp_t  iresp,
    input  redirect_t   branch_redir,
    input  redirect_t   exc_redir,
    input  logic        dec_stall,
    output fetch_slot_t [1:0] slots,
    output logic        slots_valid
);

    word_t pc;
    logic  pc_except;
    logic  pc_advance;
    logic  req_valid;
    logic  capture;
    logic  out_flush;
    logic  held;

    // request goes out at the current fetch PC
    assign ireq.valid = req_valid;
    assign ireq.addr  = pc;

    fetch_ctrl fetch_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .dec_stall    (dec_stall),
        .held         (held),
        .pc_except    (pc_except),
        .iresp        (iresp),
        .branch_redir (branch_redir),
        .exc_redir    (exc_redir),
        .req_valid    (req_valid),
        .pc_advance   (pc_advance),
        .capture      (capture),
        .out_flush    (out_flush)
    );

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) pc_gen_i (
        .clk          (clk),
        .reset        (reset),
        .pc_advance   (pc_advance),
        .branch_redir (branch_redir),
        .exc_redir    (exc_redir),
        .pc           (pc),
        .pc_except    (pc_except)
    );

    fetch_align fetch_align_i (
        .clk         (clk),
        .reset       (reset),
        .capture     (capture),
        .out_flush   (out_flush),
        .dec_stall   (dec_stall),
        .fetch_pc    (pc),
        .pc_except   (pc_except),
        .iresp       (iresp),
        .slots       (slots),
        .slots_valid (slots_valid),
        .held        (held)
    );

endmodule

// File: verif/ibus_model.sv
`timescale 1ns/1ps

module ibus_model import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  ibus_req_t  ireq,
    output ibus_resp_t iresp
);

    localparam word_t DATA_KEY = 32'h5a5a0000;

    logic [31:0] rng;
    logic        busy;
    logic [1:0]  acc_cnt;
    logic [2:0]  data_cnt;
    word_t       line_addr;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            rng      <= 32'd19424;
            busy     <= 1'b0;
            acc_cnt  <= 2'd0;
            data_cnt <= 3'd0;
            iresp    <= '0;
        end else if (busy) begin
            if (iresp.data_ok) begin
                // back to idle and pick the next accept delay
                busy          <= 1'b0;
                iresp.data_ok <= 1'b0;
                iresp.addr_ok <= (rng % 3) == 0;
                acc_cnt       <= 2'(rng % 3);
                rng           <= xorshift32(rng);
            end else if (data_cnt == 3'd1) begin
                // word contents follow from the address alone
                iresp.data_ok <= 1'b1;
                iresp.data    <= {(line_addr + 32'd4) ^ DATA_KEY, line_addr ^ DATA_KEY};
                data_cnt      <= 3'd0;
            end else begin
                data_cnt <= data_cnt - 3'd1;
            end
        end else if (ireq.valid) begin
            if (iresp.addr_ok) begin
                busy          <= 1'b1;
                iresp.addr_ok <= 1'b0;
                line_addr     <= {ireq.addr[31:3], 3'b000};
                data_cnt      <= 3'd1 + rng[9:8];
                rng           <= xorshift32(rng);
            end else if (acc_cnt <= 2'd1) begin
                iresp.addr_ok <= 1'b1;
                acc_cnt       <= 2'd0;
            end else begin
                acc_cnt <= acc_cnt - 2'd1;
            end
        end
    end

endmodule

// File: verif/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch import core_pkg::*; ();

    typedef fetch_slot_t [1:0] packet_t;

    localparam word_t     RESET_PC = 32'hbfc0_0000;
    localparam word_t     DATA_KEY = 32'h5a5a0000;
    localparam int        TIMEOUT  = 100;
    localparam redirect_t NO_REDIR = '0;

    logic       clk;
    logic       reset;
    logic       dec_stall;
    ibus_req_t  ireq;
    ibus_resp_t iresp;
    redirect_t  branch_redir;
    redirect_t  exc_redir;
    packet_t    slots;
    logic       slots_valid;
    word_t      exp_pc;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    fetch_top #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .ireq         (ireq),
        .iresp        (iresp),
        .branch_redir (branch_redir),
        .exc_redir    (exc_redir),
        .dec_stall    (dec_stall),
        .slots        (slots),
        .slots_valid  (slots_valid)
    );

    ibus_model ibus_model_i (
        .clk   (clk),
        .reset (reset),
        .ireq  (ireq),
        .iresp (iresp)
    );

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        assert (actual === expected) else begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("ERRORS FOUND");
        $fatal(1, "wait timed out");
    endtask

    // next doubleword after the one holding pc
    function automatic word_t next_fetch_pc(input word_t pc);
        return {pc[31:3], 3'b000} + 32'd8;
    endfunction

    function automatic redirect_t make_redir(input word_t target);
        redirect_t r;
        r.valid  = 1'b1;
        r.target = target;
        return r;
    endfunction

    task automatic wait_packet(input string what, input logic bus_idle, output packet_t pkt);
        for (int i = 0; i < TIMEOUT; i++) begin
            @(posedge clk);
            if (bus_idle) begin
                check_value(ireq.valid, 1'b0, "ireq.valid for a misaligned PC");
            end
            if (slots_valid) begin
                pkt = slots;
                return;
            end
        end
        report_timeout(what);
    endtask

    task automatic wait_accept();
        for (int i = 0; i < TIMEOUT; i++) begin
            @(posedge clk);
            if (ireq.valid && iresp.addr_ok) begin
                return;
            end
        end
        report_timeout("a bus request to be accepted");
    endtask

    task automatic check_packet(input packet_t pkt, input word_t pc);
        check_value(pkt[0].valid, 1'b1, "slot 0 valid");
        check_value(pkt[0].pc, pc, "slot 0 pc");
        check_value(pkt[0].raw_instr, pc ^ DATA_KEY, "slot 0 instruction");
        check_value(pkt[0].pc_except, 1'b0, "slot 0 pc_except");
        // odd word start leaves slot 1 empty
        check_value(pkt[1].valid, !pc[2], "slot 1 valid");
        if (!pc[2]) begin
            check_value(pkt[1].pc, pc + 32'd4, "slot 1 pc");
            check_value(pkt[1].raw_instr, (pc + 32'd4) ^ DATA_KEY, "slot 1 instruction");
        end
    endtask

    task automatic expect_stream(input word_t first_pc, input int count);
        packet_t pkt;
        word_t   pc;
        pc = first_pc;
        for (int n = 0; n < count; n++) begin
            wait_packet("the next packet", 1'b0, pkt);
            check_packet(pkt, pc);
            pc = next_fetch_pc(pc);
        end
        exp_pc = pc;
    endtask

    // drives a one-cycle strobe starting at a rising edge
    task automatic send_redirect(input redirect_t br, input redirect_t ex);
        branch_redir <= br;
        exc_redir    <= ex;
        @(posedge clk);
        branch_redir <= NO_REDIR;
        exc_redir    <= NO_REDIR;
        @(posedge clk);
        check_value(slots_valid, 1'b0, "slots_valid after a redirect");
    endtask

    task automatic stream_after_reset();
        @(posedge clk);
        check_value(ireq.valid, 1'b1, "ireq.valid after reset");
        check_value(ireq.addr, RESET_PC, "ireq.addr after reset");
        check_value(slots_valid, 1'b0, "slots_valid after reset");
        expect_stream(RESET_PC, 4);
    endtask

    task automatic odd_word_target();
        send_redirect(make_redir(32'h0000_1004), NO_REDIR);
        expect_stream(32'h0000_1004, 3);
    endtask

    task automatic branch_while_in_flight();
        wait_accept();
        // the accepted request is outstanding and its data must not show up
        send_redirect(make_redir(32'h0000_2000), NO_REDIR);
        expect_stream(32'h0000_2000, 3);
    endtask

    task automatic stall_and_release();
        packet_t first;
        int      accepts;
        accepts = 0;
        dec_stall <= 1'b1;
        wait_packet("a packet under stall", 1'b0, first);
        check_packet(first, exp_pc);
        repeat (10) begin
            @(posedge clk);
            assert (slots === first && slots_valid === 1'b1) else begin
                $display("mismatch at %0t ns: packet changed while decode was stalled", $time);
                $display("ERRORS FOUND");
                $fatal(1, "stall check failed");
            end
            // only the doubleword after the held packet may be requested
            if (ireq.valid && iresp.addr_ok) begin
                accepts++;
            end
            assert (accepts <= 1) else begin
                $display("mismatch at %0t ns: second bus request while decode was stalled",
                         $time);
                $display("ERRORS FOUND");
                $fatal(1, "stall check failed");
            end
        end
        dec_stall <= 1'b0;
        // release cycle still shows the held packet
        @(posedge clk);
        check_value(slots[0].pc, exp_pc, "held packet pc in the release cycle");
        expect_stream(next_fetch_pc(exp_pc), 3);
    endtask

    task automatic exc_over_branch();
        send_redirect(make_redir(32'h0000_2400), make_redir(32'h0000_0380));
        expect_stream(32'h0000_0380, 2);
    endtask

    task automatic misaligned_target();
        packet_t pkt;
        send_redirect(make_redir(32'h0000_3002), NO_REDIR);
        wait_packet("the fetch exception packet", 1'b1, pkt);
        check_value(pkt[0].valid, 1'b1, "exception slot valid");
        check_value(pkt[0].pc, 32'h0000_3002, "exception slot pc");
        check_value(pkt[0].pc_except, 1'b1, "exception slot pc_except");
        check_value(pkt[0].raw_instr, 32'h0, "exception slot instruction");
        check_value(pkt[1].valid, 1'b0, "slot 1 valid with an exception");
        // parked in F_EXC
        repeat (12) begin
            @(posedge clk);
            check_value(ireq.valid, 1'b0, "ireq.valid while parked");
            check_value(slots_valid, 1'b0, "slots_valid while parked");
        end
        send_redirect(make_redir(32'h0000_4000), NO_REDIR);
        expect_stream(32'h0000_4000, 2);
    endtask

    initial begin
        reset        = 1'b1;
        dec_stall    = 1'b0;
        branch_redir = NO_REDIR;
        exc_redir    = NO_REDIR;
        exp_pc       = RESET_PC;
        repeat (5) @(posedge clk);
        check_value(ireq.valid, 1'b0, "ireq.valid during reset");
        reset <= 1'b0;
        stream_after_reset();
        odd_word_target();
        branch_while_in_flight();
        stall_and_release();
        exc_over_branch();
        misaligned_target();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: project.f
design/core_pkg.sv
design/fetch_ctrl.sv
design/pc_gen.sv
design/fetch_align.sv
design/fetch_top.sv
verif/ibus_model.sv
verif/tb_fetch.sv
